// File: sim.f
calc_pkg.sv
calc_addsub.sv
calc_multiplier.sv
calc_controller.sv
calc_top.sv
calc_tb.sv

// File: Bender.yml
package:
  name: calc

sources:
  - calc_pkg.sv
  - calc_addsub.sv
  - calc_multiplier.sv
  - calc_controller.sv
  - calc_top.sv
  - target: simulation
    files:
      - calc_tb.sv

// File: calc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module calc_tb
    import calc_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 40;
    localparam int CYCLES_PER_TEST = 60;          // Worst case entry plus multiply
    localparam int MAX_WAIT        = 30;          // Bound on cycles from equal to complete
    localparam int CYCLE_LIMIT     = RESET_CYCLES + 32 + NUM_TESTS * CYCLES_PER_TEST;

    logic       clk;
    logic       nRST;
    logic [3:0] keypad;
    logic       read_input;
    op_t        op_key;
    logic       equal_key;
    logic       complete;
    data_t      display;

    integer seed;
    int     cycle_count = 0;
    int     err_count;
    int     pass_count;
    int     fail_count;
    data_t  display_prev;                         // Last display seen by the monitor

    calc_top #(
        .SLICE_W (4)
    ) u_calc_top (
        .clk        (clk),
        .nRST       (nRST),
        .keypad     (keypad),
        .read_input (read_input),
        .op_key     (op_key),
        .equal_key  (equal_key),
        .complete   (complete),
        .display    (display)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) @(posedge clk);
        $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    function automatic int rand_below(int n);
        return {$random(seed)} % n;
    endfunction

    // Decimal entry rule modulo 2^16
    function automatic data_t next_operand(data_t val, logic [3:0] key);
        return data_t'(32'(val) * 10 + 32'(key));
    endfunction

    function automatic data_t expected_result(op_t op, data_t a, data_t b);
        logic [2*DATA_W-1:0] prod;
        prod = a * b;                             // Full 32-bit product
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return prod[DATA_W-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic op_t invalid_op();
        case (rand_below(5))
            0:       return op_t'(3'b000);
            1:       return op_t'(3'b011);
            2:       return op_t'(3'b101);
            3:       return op_t'(3'b110);
            default: return op_t'(3'b111);
        endcase
    endfunction

    function automatic string op_name(op_t op);
        case (op)
            OP_ADD:  return "add";
            OP_SUB:  return "sub";
            OP_MUL:  return "mul";
            default: return "none";
        endcase
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    // Display may only move together with complete
    task automatic watch_outputs();
        if (!complete && display !== display_prev) begin
            $display("Display changed from %h to %h without a complete pulse",
                     display_prev, display);
            err_count++;
        end
        display_prev = display;
    endtask

    task automatic drive_cycle(input logic rd, input logic [3:0] key, input op_t op,
                               input logic eq);
        @(negedge clk);
        watch_outputs();
        read_input = rd;
        keypad     = key;
        op_key     = op;
        equal_key  = eq;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 4'(rand_below(16)), OP_NONE, 1'b0);   // Key ignored without strobe
    endtask

    // bad_pos below zero means no invalid operator press
    task automatic enter_operand(input int ndigits, input int bad_pos, output data_t val);
        int         j;
        logic [3:0] key;
        val = '0;
        for (j = 0; j < ndigits; j++) begin
            repeat (rand_below(3)) idle_cycle();
            if (j == bad_pos) begin
                drive_cycle(1'b0, 4'h0, invalid_op(), 1'b0);
            end
            key = 4'(rand_below(16));
            drive_cycle(1'b1, key, OP_NONE, 1'b0);
            val = next_operand(val, key);
        end
    endtask

    task automatic report_test(input string name, input int err_before, input string detail);
        if (err_count == err_before) begin
            pass_count++;
            $display("Test %s passed %s", name, detail);
        end else begin
            fail_count++;
            $display("Test %s found %0d errors", name, err_count - err_before);
        end
    endtask

    task automatic check_reset_idle();
        int err_before;
        err_before = err_count;
        repeat (8) begin
            idle_cycle();
            check_data("reset_idle display", '0, display);
            check_flag("reset_idle complete", 1'b0, complete);
        end
        report_test("reset_idle", err_before, "");
    endtask

    task automatic run_calculation(input int idx);
        op_t   op;
        data_t a;
        data_t b;
        data_t exp;
        string name;
        int    bad_pos;
        int    waited;
        int    err_before;
        int    n_a;
        err_before = err_count;
        case (rand_below(3))
            0:       op = OP_ADD;
            1:       op = OP_SUB;
            default: op = OP_MUL;
        endcase
        n_a     = 1 + rand_below(5);
        bad_pos = (idx % 4 == 3) ? rand_below(n_a) : -1;
        name    = $sformatf("t%0d_%s%s", idx, op_name(op), (bad_pos >= 0) ? "_badop" : "");

        enter_operand(n_a, bad_pos, a);
        drive_cycle(1'b0, 4'h0, op, 1'b0);
        enter_operand(1 + rand_below(5), -1, b);
        drive_cycle(1'b0, 4'h0, OP_NONE, 1'b1);            // Equal key
        exp = expected_result(op, a, b);

        // Strobes while the unit runs must be ignored
        waited = 0;
        do begin
            drive_cycle(1'(rand_below(2)), 4'(rand_below(16)), OP_NONE, 1'b0);
            waited++;
        end while (!complete && waited < MAX_WAIT);

        if (!complete) begin
            $display("Test %s saw no complete pulse within %0d cycles of equal",
                     name, MAX_WAIT);
            err_count++;
        end else begin
            check_data({name, " display"}, exp, display);
            idle_cycle();
            check_flag({name, " complete width"}, 1'b0, complete);
        end
        repeat (rand_below(4)) idle_cycle();
        report_test(name, err_before, $sformatf("(%0d %s %0d = %0d)", a, op_name(op), b, exp));
    endtask

    initial begin
        int i;
        seed       = 32'h3cd9;
        nRST       = 1'b0;
        keypad     = 4'h0;
        read_input = 1'b0;
        op_key     = OP_NONE;
        equal_key  = 1'b0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nRST         = 1'b1;
        display_prev = display;

        check_reset_idle();
        for (i = 0; i < NUM_TESTS; i++) begin
            run_calculation(i);
        end

        $display("Summary: %0d tests passed, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: calc_top.sv
`timescale 1ns/1ns
`default_nettype none

module calc_top
    import calc_pkg::*;
#(
    parameter int SLICE_W = 4             // Adder bits per clock
) (
    input  wire logic       clk,
    input  wire logic       nRST,
    input  wire logic [3:0] keypad,
    input  wire logic       read_input,
    input  wire op_t        op_key,
    input  wire logic       equal_key,
    output logic            complete,     // One-cycle result strobe
    output data_t           display
);

    calc_controller #(
        .SLICE_W (SLICE_W)
    ) u_controller (
        .clk        (clk),
        .nRST       (nRST),
        .keypad     (keypad),
        .read_input (read_input),
        .op_key     (op_key),
        .equal_key  (equal_key),
        .complete   (complete),
        .display    (display)
    );

endmodule

`default_nettype wire

// File: calc_controller.sv
`timescale 1ns/1ns
`default_nettype none

module calc_controller
    import calc_pkg::*;
#(
    parameter int SLICE_W = 4
) (
    input  wire logic       clk,
    input  wire logic       nRST,
    input  wire logic [3:0] keypad,       // One decimal digit
    input  wire logic       read_input,   // Digit strobe
    input  wire op_t        op_key,
    input  wire logic       equal_key,
    output logic            complete,
    output data_t           display
);

    typedef enum logic [2:0] {
        S_FIRST,                          // Collect left operand
        S_SECOND,                         // Collect right operand
        S_ISSUE,
        S_WAIT,
        S_SHOW
    } state_t;

    state_t    state_q;
    state_t    state_d;
    operands_t opnd_q;
    op_t       op_q;                      // Operator latched at key press

    logic  as_start;
    logic  as_finish;
    logic  sub;
    data_t as_result;
    logic  mul_start;
    logic  mul_finish;
    data_t mul_result;

    // operand * 10 + digit modulo 2^DATA_W
    function automatic data_t push_digit(data_t val, logic [3:0] key);
        return (val << 3) + (val << 1) + data_t'(key);
    endfunction

    function automatic logic is_valid_op(op_t op);
        return op inside {OP_ADD, OP_SUB, OP_MUL};
    endfunction

    calc_addsub #(
        .SLICE_W (SLICE_W)
    ) u_addsub (
        .clk      (clk),
        .nRST     (nRST),
        .start    (as_start),
        .sub      (sub),
        .operands (opnd_q),
        .result   (as_result),
        .finish   (as_finish)
    );

    calc_multiplier u_multiplier (
        .clk      (clk),
        .nRST     (nRST),
        .start    (mul_start),
        .operands (opnd_q),
        .result   (mul_result),
        .finish   (mul_finish)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FIRST: begin
                if (is_valid_op(op_key)) begin
                    state_d = S_SECOND;
                end
            end
            S_SECOND: begin
                if (equal_key) begin
                    state_d = S_ISSUE;
                end
            end
            S_ISSUE: state_d = S_WAIT;
            S_WAIT: begin
                if (as_finish || mul_finish) begin
                    state_d = S_SHOW;
                end
            end
            S_SHOW:  state_d = S_FIRST;
            default: state_d = S_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q <= S_FIRST;
            opnd_q  <= '0;
            op_q    <= OP_NONE;
            display <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                S_FIRST: begin
                    if (read_input) begin
                        opnd_q.a <= push_digit(opnd_q.a, keypad);
                    end
                    if (is_valid_op(op_key)) begin
                        op_q <= op_key;           // Held until the result shows
                    end
                end
                S_SECOND: begin
                    if (read_input) begin
                        opnd_q.b <= push_digit(opnd_q.b, keypad);
                    end
                end
                S_WAIT: begin
                    // Display is valid in the same cycle as complete
                    if (as_finish) begin
                        display <= as_result;
                    end else if (mul_finish) begin
                        display <= mul_result;
                    end
                end
                S_SHOW: begin
                    opnd_q <= '0;                 // Next entry starts clean
                    op_q   <= OP_NONE;
                end
                default: begin
                end
            endcase
        end
    end

    // Operands and mode only change in entry states, so they hold while a unit runs
    assign as_start  = (state_q == S_ISSUE) && (op_q != OP_MUL);
    assign mul_start = (state_q == S_ISSUE) && (op_q == OP_MUL);
    assign sub       = (op_q == OP_SUB);
    assign complete  = (state_q == S_SHOW);

    a_op_latched: assert property (@(posedge clk) disable iff (!nRST)
        (state_q != S_FIRST) |-> is_valid_op(op_q))
        else $error("calc_controller: invalid operator past first operand");

    a_one_finish: assert property (@(posedge clk) disable iff (!nRST)
        !(as_finish && mul_finish))
        else $error("calc_controller: both units finished together");

endmodule

`default_nettype wire

// File: calc_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module calc_multiplier
    import calc_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      nRST,
    input  wire logic      start,
    input  wire operands_t operands,
    output data_t          result,
    output logic           finish
);

    localparam int CNT_W = $clog2(DATA_W);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] idx;
    logic             active;
    logic             last;
    data_t            mcand_q;       // Multiplicand shifting left
    data_t            mplier_q;      // Multiplier shifting right
    data_t            acc_q;
    data_t            cur_mcand;
    data_t            cur_mplier;
    data_t            cur_acc;
    data_t            acc_next;

    // Step 0 uses the fresh operands and a cleared accumulator
    always_comb begin
        active     = start || busy_q;
        idx        = start ? '0 : cnt_q;
        last       = (idx == CNT_W'(DATA_W - 1));
        cur_mcand  = start ? operands.a : mcand_q;
        cur_mplier = start ? operands.b : mplier_q;
        cur_acc    = start ? '0 : acc_q;
        acc_next   = cur_acc + (cur_mplier[0] ? cur_mcand : '0);
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= active && last;
            if (active) begin
                busy_q <= !last;
                cnt_q  <= idx + 1'b1;
            end
        end
    end

    // Bits shifted past DATA_W drop out, so only the low half builds up
    always_ff @(posedge clk) begin
        if (active) begin
            mcand_q  <= cur_mcand << 1;
            mplier_q <= cur_mplier >> 1;
            acc_q    <= acc_next;
        end
    end

    assign result = acc_q;

    a_start_idle: assert property (@(posedge clk) disable iff (!nRST) start |-> !busy_q)
        else $error("calc_multiplier: start while busy");

endmodule

`default_nettype wire

// File: calc_addsub.sv
`timescale 1ns/1ns
`default_nettype none

module calc_addsub
    import calc_pkg::*;
#(
    parameter int SLICE_W = 4
) (
    input  wire logic      clk,
    input  wire logic      nRST,
    input  wire logic      start,
    input  wire logic      sub,      // 1 selects a - b
    input  wire operands_t operands,
    output data_t          result,
    output logic           finish
);

    localparam int NSLICE = DATA_W / SLICE_W;
    localparam int CNT_W  = (NSLICE > 1) ? $clog2(NSLICE) : 1;

    if (DATA_W % SLICE_W != 0) begin : g_slice_check
        $error("SLICE_W must divide DATA_W");
    end

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] idx;
    logic             active;
    logic             last;
    data_t            a_q;
    data_t            b_q;
    data_t            sum_q;
    data_t            cur_a;
    data_t            cur_b;
    logic             carry_q;
    logic             cur_c;
    logic [SLICE_W:0] slice_sum;

    // Slice 0 is taken straight from the operands in the start cycle
    always_comb begin
        active    = start || busy_q;
        idx       = start ? '0 : cnt_q;
        last      = (idx == CNT_W'(NSLICE - 1));
        cur_a     = start ? operands.a : a_q;
        cur_b     = start ? (operands.b ^ {DATA_W{sub}}) : b_q;   // Two's complement of b
        cur_c     = start ? sub : carry_q;
        slice_sum = {1'b0, cur_a[SLICE_W-1:0]} + {1'b0, cur_b[SLICE_W-1:0]}
                  + {{SLICE_W{1'b0}}, cur_c};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= active && last;                 // Last slice lands this edge
            if (active) begin
                busy_q <= !last;
                cnt_q  <= idx + 1'b1;
            end
        end
    end

    // Sum fills from the top, one slice per clock
    always_ff @(posedge clk) begin
        if (active) begin
            a_q     <= cur_a >> SLICE_W;
            b_q     <= cur_b >> SLICE_W;
            carry_q <= slice_sum[SLICE_W];            // Ripple into next slice
            sum_q   <= (sum_q >> SLICE_W)
                     | (data_t'(slice_sum[SLICE_W-1:0]) << (DATA_W - SLICE_W));
        end
    end

    assign result = sum_q;

    a_start_idle: assert property (@(posedge clk) disable iff (!nRST) start |-> !busy_q)
        else $error("calc_addsub: start while busy");

    a_finish_pulse: assert property (@(posedge clk) disable iff (!nRST) finish |=> !finish)
        else $error("calc_addsub: finish longer than one cycle");

endmodule

`default_nettype wire

// File: calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Width of operands, results and the display
    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] data_t;

    // The controller accepts only the one-hot operator keys
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } op_t;

    // Operand pair handed to both arithmetic units
    typedef struct packed {
        data_t a;                     // Left operand
        data_t b;                     // Right operand
    } operands_t;

endpackage

`default_nettype wire
